// File: rtl/fp_defines.svh
/*
 * Sizing constants for the FP register path.
 * Included by the package and by any module that sizes ports from them.
 */
`ifndef FP_DEFINES_SVH
`define FP_DEFINES_SVH

// Register width, double precision supported
`define FP_FLEN 64

// Architectural register count f0..f31
`define FP_NREGS 32

// Register address width
`define FP_AW 5

// Result buffer depth between issue and writeback
`define FP_WB_DEPTH 4

// Canonical single-precision quiet NaN
`define FP_CANON_NAN_S 32'h7fc00000

`endif

// File: rtl/fp_pkg.sv
/*
 * Shared types for the FP register path.
 * Modules pull these in with a wildcard import in their header.
 */
`default_nettype none

`include "fp_defines.svh"

package fp_pkg;

  // Operations accepted at the issue boundary
  typedef enum logic [2:0] {
    FP_SGNJ  = 3'd0,
    FP_SGNJN = 3'd1,
    FP_SGNJX = 3'd2,
    FP_MV_X  = 3'd3
  } fp_op_e;

  // One architectural FP register
  typedef logic [`FP_FLEN-1:0] fp_word_t;

  // Result travelling from issue to writeback
  // Single marks a value that needs NaN boxing on write
  typedef struct packed {
    logic [`FP_AW-1:0] rd;
    fp_word_t          data;
    logic              single;
  } fp_wb_entry_t;

endpackage

`default_nettype wire

// File: rtl/fp_register_file.sv
/*
 * Architectural FP registers f0..f31 with three combinational reads.
 * Single write port applies NaN boxing for single-precision values.
 */
`timescale 1ns/1ns
`default_nettype none

`include "fp_defines.svh"

module fp_register_file
  import fp_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset_n,

  // Read ports, rs3 serves the store unit
  input  wire logic [`FP_AW-1:0] rs1_addr,
  input  wire logic [`FP_AW-1:0] rs2_addr,
  input  wire logic [`FP_AW-1:0] rs3_addr,
  output fp_word_t               rs1_data,
  output fp_word_t               rs2_data,
  output fp_word_t               rs3_data,

  // Write port
  input  wire logic              wr_en,
  input  wire logic [`FP_AW-1:0] rd_addr,
  input  wire fp_word_t          rd_data,
  input  wire logic              write_single
);

  // Width of the box above a single-precision value
  localparam int BOX_W = `FP_FLEN - 32;

  fp_word_t regs [`FP_NREGS];
  fp_word_t wr_value;

  // All three reads are plain array lookups
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];
  assign rs3_data = regs[rs3_addr];

  // Single writes get all ones above bit 31
  assign wr_value = write_single ? {{BOX_W{1'b1}}, rd_data[31:0]} : rd_data;

  // f0 is an ordinary register here, no hardwired zero
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      // Every register comes up as +0.0
      for (int i = 0; i < `FP_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rd_addr] <= wr_value;
    end
  end

endmodule

`default_nettype wire

// File: rtl/fp_issue_stage.sv
/*
 * Issue stage: accepts four-phase requests, tracks busy registers,
 * unboxes single sources and computes sign-injection or move results.
 * Results leave through a valid/ready push toward the writeback buffer.
 */
`timescale 1ns/1ns
`default_nettype none

`include "fp_defines.svh"

module fp_issue_stage
  import fp_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset_n,

  // Four-phase request side
  input  wire logic              req,
  output logic                   ack,
  input  wire fp_op_e            op,
  input  wire logic              single,
  input  wire logic [`FP_AW-1:0] rd,
  input  wire logic [`FP_AW-1:0] rs1,
  input  wire logic [`FP_AW-1:0] rs2,
  input  wire fp_word_t          int_data,

  // Register file reads
  output logic [`FP_AW-1:0]      rs1_addr,
  output logic [`FP_AW-1:0]      rs2_addr,
  input  wire fp_word_t          rs1_data,
  input  wire fp_word_t          rs2_data,

  // Result push
  output logic                   push_valid,
  input  wire logic              push_ready,
  output fp_wb_entry_t           push_entry,

  // Scoreboard release from writeback
  input  wire logic              retire,
  input  wire logic [`FP_AW-1:0] retire_rd,

  output logic                   idle
);

  localparam int BOX_W = `FP_FLEN - 32;

  logic [`FP_NREGS-1:0] busy;
  logic                 hazard;
  logic                 push_fire;
  logic [31:0]          a_s;
  logic [31:0]          b_s;
  logic                 sign_a;
  logic                 sign_b;
  logic                 sign_r;
  fp_word_t             result;

  // Improperly boxed single source reads as canonical NaN
  function automatic logic [31:0] unbox_s(input fp_word_t v);
    logic boxed;
    boxed = &v[`FP_FLEN-1:32];
    return boxed ? v[31:0] : `FP_CANON_NAN_S;
  endfunction

  // Sources go straight to the register file read ports
  assign rs1_addr = rs1;
  assign rs2_addr = rs2;

  // Wait on any register with a result still in flight
  assign hazard = busy[rs1] | busy[rs2] | busy[rd];

  // Offer the result once per request, before ack goes up
  assign push_valid = req & ~ack & ~hazard;
  assign push_fire  = push_valid & push_ready;

  always_comb begin
    a_s    = unbox_s(rs1_data);
    b_s    = unbox_s(rs2_data);
    sign_a = single ? a_s[31] : rs1_data[`FP_FLEN-1];
    sign_b = single ? b_s[31] : rs2_data[`FP_FLEN-1];

    // Sign source per operation
    case (op)
      FP_SGNJN: sign_r = ~sign_b;
      FP_SGNJX: sign_r = sign_a ^ sign_b;
      default:  sign_r = sign_b;
    endcase

    if (op == FP_MV_X) begin
      // Integer bits moved unchanged, low word only for single
      result = single ? {{BOX_W{1'b1}}, int_data[31:0]} : int_data;
    end else if (single) begin
      result = {{BOX_W{1'b1}}, sign_r, a_s[30:0]};
    end else begin
      // Magnitude of rs1 under the chosen sign
      result = {sign_r, rs1_data[`FP_FLEN-2:0]};
    end
  end

  assign push_entry = '{rd: rd, data: result, single: single};

  // Ack rises with the push and drops once req is seen low
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ack <= 1'b0;
    end else if (push_fire) begin
      ack <= 1'b1;
    end else if (ack && !req) begin
      ack <= 1'b0;
    end
  end

  // Scoreboard
  // A push to the same register as a retire keeps the bit set
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy <= '0;
    end else begin
      if (retire) begin
        busy[retire_rd] <= 1'b0;
      end
      if (push_fire) begin
        busy[rd] <= 1'b1;
      end
    end
  end

  // Nothing in flight and no handshake open
  assign idle = ~(|busy) & ~ack;

endmodule

`default_nettype wire

// File: rtl/fp_writeback_fifo.sv
/*
 * Circular FIFO holding results between issue and writeback.
 * Payload type is set by the instantiating module.
 */
`timescale 1ns/1ns
`default_nettype none

`include "fp_defines.svh"

module fp_writeback_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  wire logic     clk,
  input  wire logic     reset_n,

  input  wire logic     push_valid,
  output logic          push_ready,
  input  wire payload_t push_entry,

  output logic          pop_valid,
  input  wire logic     pop_ready,
  output payload_t      pop_entry
);

  localparam int DEPTH = `FP_WB_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign push_ready = (count != CNT_W'(DEPTH));
  assign pop_valid  = (count != '0);
  assign pop_entry  = mem[rd_ptr];

  assign do_push = push_valid & push_ready;
  assign do_pop  = pop_valid & pop_ready;

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_entry;
    end
  end

  // Pointers wrap at depth, count tracks occupancy
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave count unchanged
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/fp_writeback_unit.sv
/*
 * Writeback stage. Shares the register file write port between loads
 * and buffered results, loads first, and retires scoreboard entries.
 */
`timescale 1ns/1ns
`default_nettype none

`include "fp_defines.svh"

module fp_writeback_unit
  import fp_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset_n,

  // Result buffer head
  input  wire logic              pop_valid,
  output logic                   pop_ready,
  input  wire fp_wb_entry_t      pop_entry,

  // Load port written in the cycle it is presented
  input  wire logic              load_valid,
  input  wire logic [`FP_AW-1:0] load_rd,
  input  wire fp_word_t          load_data,
  input  wire logic              load_single,

  // Register file write
  output logic                   wr_en,
  output logic [`FP_AW-1:0]      rd_addr,
  output fp_word_t               rd_data,
  output logic                   write_single,

  // Scoreboard release
  output logic                   retire,
  output logic [`FP_AW-1:0]      retire_rd
);

  logic         stage_valid;
  fp_wb_entry_t stage_entry;
  logic         stage_written;

  // Staged result writes only when no load holds the port
  assign stage_written = stage_valid & ~load_valid;

  // Refill when empty or emptying this cycle
  assign pop_ready = ~stage_valid | stage_written;

  // Write port mux with load priority
  assign wr_en        = load_valid | stage_valid;
  assign rd_addr      = load_valid ? load_rd     : stage_entry.rd;
  assign rd_data      = load_valid ? load_data   : stage_entry.data;
  assign write_single = load_valid ? load_single : stage_entry.single;

  assign retire    = stage_written;
  assign retire_rd = stage_entry.rd;

  // Next result to be written, taken from the FIFO head
  always_ff @(posedge clk) begin
    if (pop_valid && pop_ready) begin
      stage_entry <= pop_entry;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      stage_valid <= 1'b0;
    end else if (pop_valid && pop_ready) begin
      stage_valid <= 1'b1;
    end else if (stage_written) begin
      stage_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/fp_subsystem_top.sv
/*
 * FP register path top. Issue stage feeds a result FIFO drained
 * by the writeback unit into the register file. Store reads use rs3.
 */
`timescale 1ns/1ns
`default_nettype none

`include "fp_defines.svh"

module fp_subsystem_top
  import fp_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset_n,

  // Four-phase issue interface
  input  wire logic              req,
  output logic                   ack,
  input  wire fp_op_e            op,
  input  wire logic              single,
  input  wire logic [`FP_AW-1:0] rd,
  input  wire logic [`FP_AW-1:0] rs1,
  input  wire logic [`FP_AW-1:0] rs2,
  input  wire fp_word_t          int_data,

  // Load writeback
  input  wire logic              load_valid,
  input  wire logic [`FP_AW-1:0] load_rd,
  input  wire fp_word_t          load_data,
  input  wire logic              load_single,

  // Store read
  input  wire logic [`FP_AW-1:0] store_rs,
  output fp_word_t               store_data,

  output logic                   idle
);

  logic [`FP_AW-1:0] rs1_addr;
  logic [`FP_AW-1:0] rs2_addr;
  fp_word_t          rs1_data;
  fp_word_t          rs2_data;

  logic              push_valid;
  logic              push_ready;
  fp_wb_entry_t      push_entry;
  logic              pop_valid;
  logic              pop_ready;
  fp_wb_entry_t      pop_entry;

  logic              wr_en;
  logic [`FP_AW-1:0] rd_addr;
  fp_word_t          rd_data;
  logic              write_single;
  logic              retire;
  logic [`FP_AW-1:0] retire_rd;

  fp_issue_stage fp_issue_stage_i (
    .clk, .reset_n,
    .req, .ack, .op, .single, .rd, .rs1, .rs2, .int_data,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .push_valid, .push_ready, .push_entry,
    .retire, .retire_rd,
    .idle
  );

  fp_writeback_fifo #(
    .payload_t(fp_wb_entry_t)
  ) fp_writeback_fifo_i (
    .clk, .reset_n,
    .push_valid, .push_ready, .push_entry,
    .pop_valid, .pop_ready, .pop_entry
  );

  fp_writeback_unit fp_writeback_unit_i (
    .clk, .reset_n,
    .pop_valid, .pop_ready, .pop_entry,
    .load_valid, .load_rd, .load_data, .load_single,
    .wr_en, .rd_addr, .rd_data, .write_single,
    .retire, .retire_rd
  );

  // Third read port carries store data
  fp_register_file fp_register_file_i (
    .clk, .reset_n,
    .rs1_addr, .rs2_addr,
    .rs3_addr (store_rs),
    .rs1_data, .rs2_data,
    .rs3_data (store_data),
    .wr_en, .rd_addr, .rd_data, .write_single
  );

endmodule

`default_nettype wire

// File: tests/tb_fp_subsystem.sv
/*
 * Random-stimulus testbench for the FP register path top level.
 * Keeps a register model in step with issued ops and loads, reads back
 * through the store port while idle, and watches the four-phase handshake.
 */
`timescale 1ns/1ns
`default_nettype none

`include "fp_defines.svh"

module tb_fp_subsystem
  import fp_pkg::*;
;

  localparam int  N_OPS       = 300;
  localparam int  ACK_LIMIT   = 40;
  localparam int  IDLE_LIMIT  = 40;
  // 400 ops of 40 cycles at 40 ns
  localparam time WATCHDOG_NS = 400 * 40 * 40;

  logic              clk;
  logic              reset_n;
  logic              req;
  logic              ack;
  fp_op_e            op;
  logic              single;
  logic [`FP_AW-1:0] rd;
  logic [`FP_AW-1:0] rs1;
  logic [`FP_AW-1:0] rs2;
  fp_word_t          int_data;
  logic              load_valid;
  logic [`FP_AW-1:0] load_rd;
  fp_word_t          load_data;
  logic              load_single;
  logic [`FP_AW-1:0] store_rs;
  fp_word_t          store_data;
  logic              idle;

  // Reference register contents
  fp_word_t          model_regs [`FP_NREGS];
  int                error_count;
  logic              prev_ack;

  // Stimulus scratch
  fp_op_e            op_r;
  logic              single_r;
  logic [`FP_AW-1:0] rd_r;
  logic [`FP_AW-1:0] rs1_r;
  logic [`FP_AW-1:0] rs2_r;
  logic [`FP_AW-1:0] last_rd;

  fp_subsystem_top fp_subsystem_top_i (
    .clk, .reset_n,
    .req, .ack, .op, .single, .rd, .rs1, .rs2, .int_data,
    .load_valid, .load_rd, .load_data, .load_single,
    .store_rs, .store_data,
    .idle
  );

  always #20 clk = ~clk;

  function automatic fp_word_t box_single(input logic [31:0] v);
    return {32'hffff_ffff, v};
  endfunction

  // Anything without all-ones above bit 31 is taken as canonical NaN
  function automatic logic [31:0] unbox_single(input fp_word_t v);
    if (v[`FP_FLEN-1:32] == 32'hffff_ffff) begin
      return v[31:0];
    end
    return `FP_CANON_NAN_S;
  endfunction

  function automatic fp_word_t model_result(input fp_op_e o, input logic s,
                                            input fp_word_t a, input fp_word_t b,
                                            input fp_word_t x);
    logic [31:0] a_s;
    logic [31:0] b_s;
    logic        sa;
    logic        sb;
    logic        sr;
    if (o == FP_MV_X) begin
      return s ? box_single(x[31:0]) : x;
    end
    a_s = unbox_single(a);
    b_s = unbox_single(b);
    sa  = s ? a_s[31] : a[`FP_FLEN-1];
    sb  = s ? b_s[31] : b[`FP_FLEN-1];
    case (o)
      FP_SGNJ:  sr = sb;
      FP_SGNJN: sr = ~sb;
      default:  sr = sa ^ sb;
    endcase
    // Magnitude always from rs1
    if (s) begin
      return box_single({sr, a_s[30:0]});
    end
    return {sr, a[`FP_FLEN-2:0]};
  endfunction

  function automatic fp_word_t random_word();
    return {$urandom(), $urandom()};
  endfunction

  task automatic check_word(input string what, input fp_word_t expected,
                            input fp_word_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at %0t: %s expected %h actual %h", $time, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "register value check failed");
    end
  endtask

  task automatic check_handshake(input string what, input logic expected,
                                 input logic actual);
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at %0t: %s expected %b actual %b", $time, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "handshake check failed");
    end
  endtask

  task automatic report_timeout(input string what);
    error_count++;
    $display("timeout at %0t: %s", $time, what);
    $display("TEST FAILED");
    $fatal(1, "wait limit exceeded");
  endtask

  // Polls ack just after each rising edge and returns at the drive point
  task automatic wait_ack(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > ACK_LIMIT) begin
        report_timeout("ack never reached the expected level");
      end
    end while (ack !== level);
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (idle !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > IDLE_LIMIT) begin
        report_timeout("DUT did not return to idle");
      end
    end
  endtask

  // Four-phase exchange with the model updated in issue order
  // Returns with req low, so a following op issues as soon as ack drops
  task automatic issue_op(input fp_op_e o, input logic s, input logic [`FP_AW-1:0] d,
                          input logic [`FP_AW-1:0] a, input logic [`FP_AW-1:0] b,
                          input fp_word_t x);
    model_regs[d] = model_result(o, s, model_regs[a], model_regs[b], x);
    wait_ack(1'b0);
    op       = o;
    single   = s;
    rd       = d;
    rs1      = a;
    rs2      = b;
    int_data = x;
    req      = 1'b1;
    wait_ack(1'b1);
    req = 1'b0;
  endtask

  // One-cycle load presented while idle
  task automatic load_reg(input logic [`FP_AW-1:0] d, input fp_word_t v, input logic s);
    model_regs[d] = s ? box_single(v[31:0]) : v;
    @(posedge clk);
    #2;
    load_valid  = 1'b1;
    load_rd     = d;
    load_data   = v;
    load_single = s;
    @(posedge clk);
    #2;
    load_valid = 1'b0;
    @(negedge clk);
  endtask

  task automatic read_reg(input logic [`FP_AW-1:0] r);
    @(posedge clk);
    #2;
    store_rs = r;
    @(negedge clk);
    check_word($sformatf("f%0d", r), model_regs[r], store_data);
  endtask

  task automatic sweep_regs();
    for (int r = 0; r < `FP_NREGS; r++) begin
      read_reg(5'(r));
    end
  endtask

  // Ack may only rise under req and only fall after req drops
  // Sampled after the edge and before new inputs are driven
  always @(posedge clk) begin
    #1;
    if (reset_n) begin
      if (ack && !prev_ack) begin
        check_handshake("req while ack rises", 1'b1, req);
      end
      if (!ack && prev_ack) begin
        check_handshake("req while ack falls", 1'b0, req);
      end
    end
    prev_ack = ack;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run exceeded the watchdog limit at %0t", $time);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(32'h1f65_295d));
    clk         = 1'b0;
    reset_n     = 1'b0;
    req         = 1'b0;
    op          = FP_SGNJ;
    single      = 1'b0;
    rd          = '0;
    rs1         = '0;
    rs2         = '0;
    int_data    = '0;
    load_valid  = 1'b0;
    load_rd     = '0;
    load_data   = '0;
    load_single = 1'b0;
    store_rs    = '0;
    error_count = 0;
    prev_ack    = 1'b0;
    last_rd     = '0;
    for (int r = 0; r < `FP_NREGS; r++) begin
      model_regs[r] = '0;
    end

    repeat (10) @(posedge clk);
    #2;
    reset_n = 1'b1;
    @(negedge clk);

    // Reset state with all registers at +0.0
    check_handshake("ack after reset", 1'b0, ack);
    check_handshake("idle after reset", 1'b1, idle);
    sweep_regs();

    // Directed moves in both formats
    issue_op(FP_MV_X, 1'b1, 5'd1, 5'd0, 5'd0, random_word());
    issue_op(FP_MV_X, 1'b0, 5'd2, 5'd0, 5'd0, random_word());
    wait_idle();
    read_reg(5'd1);
    read_reg(5'd2);

    // Fill the file by loads so that random doubles act as unboxed singles
    for (int r = 0; r < `FP_NREGS; r++) begin
      load_reg(5'(r), random_word(), 1'($urandom_range(0, 1)));
    end
    sweep_regs();

    // Unboxed single source turns into canonical NaN
    load_reg(5'd3, {32'h1234_5678, 32'h3f80_0000}, 1'b0);
    issue_op(FP_SGNJ, 1'b1, 5'd4, 5'd3, 5'd3, '0);
    wait_idle();
    read_reg(5'd4);

    for (int i = 0; i < N_OPS; i++) begin
      op_r     = fp_op_e'(3'($urandom_range(0, 3)));
      single_r = 1'($urandom_range(0, 1));
      rd_r     = 5'($urandom_range(0, 31));
      rs2_r    = 5'($urandom_range(0, 31));
      // Chain on the last result about a third of the time
      if ($urandom_range(0, 2) == 0) begin
        rs1_r = last_rd;
      end else begin
        rs1_r = 5'($urandom_range(0, 31));
      end
      issue_op(op_r, single_r, rd_r, rs1_r, rs2_r, random_word());
      last_rd = rd_r;

      if (i % 8 == 7) begin
        wait_idle();
        read_reg(last_rd);
      end

      // Load then a dependent op on the loaded register
      if (i % 16 == 15) begin
        wait_idle();
        rs1_r = 5'($urandom_range(0, 31));
        load_reg(rs1_r, random_word(), 1'($urandom_range(0, 1)));
        rd_r = 5'($urandom_range(0, 31));
        issue_op(fp_op_e'(3'($urandom_range(0, 2))), 1'($urandom_range(0, 1)),
                 rd_r, rs1_r, 5'($urandom_range(0, 31)), '0);
        wait_idle();
        read_reg(rd_r);
        last_rd = rd_r;
      end
    end

    wait_idle();
    sweep_regs();

    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+rtl
rtl/fp_pkg.sv
rtl/fp_register_file.sv
rtl/fp_issue_stage.sv
rtl/fp_writeback_fifo.sv
rtl/fp_writeback_unit.sv
rtl/fp_subsystem_top.sv
tests/tb_fp_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the FP register path testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  -f sources.f \
  --top-module tb_fp_subsystem \
  -Mdir obj_dir

# Log is kept even when the simulation exits with an error
./obj_dir/Vtb_fp_subsystem 2>&1 | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
